/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = core_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* files.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch_unit.sv
hw/decode_issue.sv
hw/execute_mem.sv
hw/core_top.sv
tests/tb_clock_gen.sv
tests/core_tb.sv

/* hw/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

////////////////////////////////////////////////////////////
// Core sizes
////////////////////////////////////////////////////////////

`define CORE_XLEN        32                 // Data and address width
`define CORE_REG_COUNT   32                 // Architectural registers x0..x31
`define CORE_REG_IDX_W   5                  // Register index width

////////////////////////////////////////////////////////////
// Memories and encodings
////////////////////////////////////////////////////////////

`define CORE_IMEM_DEPTH  256                // Instruction words
`define CORE_DMEM_DEPTH  256                // Data words
`define CORE_NOP         32'h0000_0013      // ADDI x0, x0, 0

`endif

/* hw/core_top.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  imem_en,       // Program load strobe
   input  logic [`CORE_XLEN-1:0] imem_data_in,
   output pipe_pkg::retire_t     retire
);

   pipe_pkg::fetch_t  fetch;                     // Fetch register to decode
   pipe_pkg::issue_t  issue;                     // Issue register to execute
   logic              stall;                     // Hazard hold back to fetch

   ////////////////////////////////////////////////////////////
   // Pipeline stages
   ////////////////////////////////////////////////////////////

   fetch_unit u_fetch (
      .clk          (clk),
      .reset        (reset),
      .imem_en      (imem_en),
      .imem_data_in (imem_data_in),
      .stall        (stall),
      .fetch        (fetch)
   );

   decode_issue u_decode (
      .clk   (clk),
      .reset (reset),
      .fetch (fetch),
      .wb    (retire),                           // Write back is the retire record
      .stall (stall),
      .issue (issue)
   );

   execute_mem u_execute (
      .clk    (clk),
      .reset  (reset),
      .issue  (issue),
      .retire (retire)
   );

endmodule

/* hw/decode_issue.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_issue (
   input  logic              clk,
   input  logic              reset,
   input  pipe_pkg::fetch_t  fetch,
   input  pipe_pkg::retire_t wb,
   output logic              stall,
   output pipe_pkg::issue_t  issue
);

   localparam int XLEN   = `CORE_XLEN;
   localparam int NREG   = `CORE_REG_COUNT;
   localparam int IDX_W  = `CORE_REG_IDX_W;

   logic [XLEN-1:0]   instr;
   isa_pkg::opcode_e  opcode;
   logic [IDX_W-1:0]  rd;
   logic [IDX_W-1:0]  rs1;
   logic [IDX_W-1:0]  rs2;
   logic [2:0]        funct3;
   logic              alt;                        // instr[30] selects SUB and SRA
   logic [XLEN-1:0]   imm_i;
   logic [XLEN-1:0]   imm_s;
   logic [XLEN-1:0]   imm_u;
   logic              use_rs1;
   logic              use_rs2;
   logic [XLEN-1:0]   regs [NREG];                // Register file, no reset
   logic [XLEN-1:0]   rs1_val;
   logic [XLEN-1:0]   rs2_val;
   logic              wb_write;
   logic [NREG-1:0]   pending;                    // Scoreboard, bit 0 stays clear
   logic [NREG-1:0]   clear_mask;
   logic [NREG-1:0]   set_mask;
   logic [NREG-1:0]   pending_live;
   logic              do_issue;
   pipe_pkg::issue_t  issue_d;
   pipe_pkg::issue_t  issue_q;

   ////////////////////////////////////////////////////////////
   // Field extraction
   ////////////////////////////////////////////////////////////

   assign instr  = fetch.valid ? fetch.instr : `CORE_NOP;  // Bubble decodes as NOP
   assign opcode = isa_pkg::opcode_e'(instr[6:0]);
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign alt    = instr[30];
   assign imm_i  = {{(XLEN-12){instr[31]}}, instr[31:20]};
   assign imm_s  = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_u  = {instr[31:12], 12'b0};

   // Register read with same cycle write back bypass
   assign wb_write = wb.valid && wb.wen;
   assign rs1_val  = (rs1 == '0) ? '0 :
                     (wb_write && wb.rd == rs1) ? wb.data : regs[rs1];
   assign rs2_val  = (rs2 == '0) ? '0 :
                     (wb_write && wb.rd == rs2) ? wb.data : regs[rs2];

   always_ff @(posedge clk) begin
      if (wb_write) begin
         regs[wb.rd] <= wb.data;
      end
   end

   ////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      issue_d            = '0;                    // Unsupported opcode stays a no-op
      issue_d.pc         = fetch.pc;
      issue_d.rd         = rd;
      issue_d.operand_a  = rs1_val;
      issue_d.operand_b  = rs2_val;
      issue_d.store_data = rs2_val;
      issue_d.alu_op     = isa_pkg::ALU_ADD;
      use_rs1            = 1'b0;
      use_rs2            = 1'b0;
      case (opcode)
         isa_pkg::OP_REG: begin
            use_rs1     = 1'b1;
            use_rs2     = 1'b1;
            issue_d.wen = 1'b1;
            case (funct3)
               3'b000:  issue_d.alu_op = alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
               3'b001:  issue_d.alu_op = isa_pkg::ALU_SLL;
               3'b010:  issue_d.alu_op = isa_pkg::ALU_SLT;
               3'b100:  issue_d.alu_op = isa_pkg::ALU_XOR;
               3'b101:  issue_d.alu_op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
               3'b110:  issue_d.alu_op = isa_pkg::ALU_OR;
               3'b111:  issue_d.alu_op = isa_pkg::ALU_AND;
               default: issue_d.wen    = 1'b0;    // SLTU not supported
            endcase
         end
         isa_pkg::OP_IMM: begin
            use_rs1           = 1'b1;
            issue_d.operand_b = imm_i;
            issue_d.wen       = 1'b1;
            case (funct3)
               3'b000:  issue_d.alu_op = isa_pkg::ALU_ADD;
               3'b010:  issue_d.alu_op = isa_pkg::ALU_SLT;
               3'b100:  issue_d.alu_op = isa_pkg::ALU_XOR;
               3'b110:  issue_d.alu_op = isa_pkg::ALU_OR;
               3'b111:  issue_d.alu_op = isa_pkg::ALU_AND;
               default: issue_d.wen    = 1'b0;    // Shift immediates and SLTIU
            endcase
         end
         isa_pkg::OP_LUI: begin
            issue_d.operand_b = imm_u;
            issue_d.alu_op    = isa_pkg::ALU_PASS_B;
            issue_d.wen       = 1'b1;
         end
         isa_pkg::OP_LOAD: begin
            use_rs1           = 1'b1;
            issue_d.operand_b = imm_i;            // Address is rs1 plus offset
            issue_d.wen       = (funct3 == 3'b010);
            issue_d.is_load   = (funct3 == 3'b010);
         end
         isa_pkg::OP_STORE: begin
            use_rs1           = 1'b1;
            use_rs2           = 1'b1;
            issue_d.operand_b = imm_s;
            issue_d.is_store  = (funct3 == 3'b010);
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Scoreboard and issue register
   ////////////////////////////////////////////////////////////

   assign clear_mask   = wb_write ? (NREG'(1) << wb.rd) : '0;
   assign pending_live = pending & ~clear_mask;    // Retiring writer frees its reg now
   assign stall        = fetch.valid && ((use_rs1 && pending_live[rs1]) ||
                                         (use_rs2 && pending_live[rs2]));
   assign do_issue     = fetch.valid && !stall;
   assign set_mask     = (do_issue && issue_d.wen && rd != '0) ? (NREG'(1) << rd) : '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         pending       <= '0;
         issue_q.valid <= 1'b0;
      end else begin
         pending       <= pending_live | set_mask;  // New writer wins over clear
         issue_q       <= issue_d;
         issue_q.valid <= do_issue;                 // Bubble while stalled
      end
   end

   assign issue = issue_q;

endmodule

/* hw/execute_mem.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module execute_mem (
   input  logic              clk,
   input  logic              reset,
   input  pipe_pkg::issue_t  issue,
   output pipe_pkg::retire_t retire
);

   localparam int XLEN    = `CORE_XLEN;
   localparam int SHAMT_W = $clog2(`CORE_XLEN);
   localparam int DMEM_AW = $clog2(`CORE_DMEM_DEPTH);

   logic [XLEN-1:0]    dmem [`CORE_DMEM_DEPTH];   // Word addressed data memory
   logic [XLEN-1:0]    alu_result;
   logic [SHAMT_W-1:0] shamt;
   logic [DMEM_AW-1:0] dmem_idx;
   logic [XLEN-1:0]    load_data;                 // Registered read port
   logic               ex_is_load;
   pipe_pkg::retire_t  ex_q;                      // Execute stage record
   pipe_pkg::retire_t  retire_q;

   ////////////////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////////////////

   assign shamt = issue.operand_b[SHAMT_W-1:0];   // Low 5 bits only

   always_comb begin
      case (issue.alu_op)
         isa_pkg::ALU_ADD:    alu_result = issue.operand_a + issue.operand_b;
         isa_pkg::ALU_SUB:    alu_result = issue.operand_a - issue.operand_b;
         isa_pkg::ALU_AND:    alu_result = issue.operand_a & issue.operand_b;
         isa_pkg::ALU_OR:     alu_result = issue.operand_a | issue.operand_b;
         isa_pkg::ALU_XOR:    alu_result = issue.operand_a ^ issue.operand_b;
         isa_pkg::ALU_SLT:    alu_result = {{(XLEN-1){1'b0}},
                                 $signed(issue.operand_a) < $signed(issue.operand_b)};
         isa_pkg::ALU_SLL:    alu_result = issue.operand_a << shamt;
         isa_pkg::ALU_SRL:    alu_result = issue.operand_a >> shamt;
         isa_pkg::ALU_SRA:    alu_result = $signed(issue.operand_a) >>> shamt;
         isa_pkg::ALU_PASS_B: alu_result = issue.operand_b;
         default:             alu_result = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Data memory
   ////////////////////////////////////////////////////////////

   assign dmem_idx = alu_result[DMEM_AW+1:2];     // Address bits 9:2

   always_ff @(posedge clk) begin
      if (issue.valid && issue.is_store) begin
         dmem[dmem_idx] <= issue.store_data;      // Store lands in execute
      end
      if (issue.valid && issue.is_load) begin
         load_data <= dmem[dmem_idx];             // Ready for the retire stage
      end
   end

   ////////////////////////////////////////////////////////////
   // Execute and retire registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_q.valid <= 1'b0;
      end else begin
         ex_q.valid <= issue.valid;
         ex_q.pc    <= issue.pc;
         ex_q.rd    <= issue.rd;
         ex_q.wen   <= issue.valid && issue.wen && (issue.rd != '0);  // x0 never written
         ex_q.data  <= alu_result;
         ex_is_load <= issue.is_load;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         retire_q.valid <= 1'b0;
      end else begin
         retire_q <= ex_q;
         if (ex_is_load) begin
            retire_q.data <= load_data;           // Load result replaces address
         end
      end
   end

   assign retire = retire_q;

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_unit (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  imem_en,
   input  logic [`CORE_XLEN-1:0] imem_data_in,
   input  logic                  stall,
   output pipe_pkg::fetch_t      fetch
);

   localparam int IMEM_AW = $clog2(`CORE_IMEM_DEPTH);
   localparam logic [`CORE_XLEN-1:0] PC_STEP = 4;

   logic [`CORE_XLEN-1:0] imem [`CORE_IMEM_DEPTH];  // Program store, no reset
   logic [IMEM_AW:0]      load_count;               // Words loaded, one extra bit for full
   logic [IMEM_AW-1:0]    load_ptr;                 // Next word to write
   logic [`CORE_XLEN-1:0] pc;
   logic [`CORE_XLEN-1:0] pc_end;                   // First byte past the program
   logic                  fetch_ok;
   pipe_pkg::fetch_t      fetch_q;

   assign load_ptr = load_count[IMEM_AW-1:0];
   assign pc_end   = {{(`CORE_XLEN-IMEM_AW-3){1'b0}}, load_count, 2'b00};
   assign fetch_ok = !imem_en && (pc < pc_end);     // Stop at end of loaded words

   ////////////////////////////////////////////////////////////
   // Program loading
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (imem_en) begin
         imem[load_ptr] <= imem_data_in;            // One word per strobe cycle
      end
   end

   ////////////////////////////////////////////////////////////
   // PC and fetch register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         load_count    <= '0;
         pc            <= '0;
         fetch_q.valid <= 1'b0;
      end else if (imem_en) begin
         load_count    <= load_count + 1'b1;
         pc            <= '0;                       // Held at 0 while loading
         fetch_q.valid <= 1'b0;
      end else if (!stall) begin
         fetch_q.valid <= fetch_ok;
         fetch_q.pc    <= pc;
         fetch_q.instr <= imem[pc[IMEM_AW+1:2]];    // Synchronous read
         if (fetch_ok) begin
            pc <= pc + PC_STEP;
         end
      end
   end

   assign fetch = fetch_q;

endmodule

/* hw/isa_pkg.sv */
`include "core_defs.svh"

package isa_pkg;

   ////////////////////////////////////////////////////////////
   // Major opcodes, instr[6:0]
   ////////////////////////////////////////////////////////////

   typedef enum logic [6:0] {
      OP_LOAD  = 7'b0000011,                // LW
      OP_IMM   = 7'b0010011,                // ADDI SLTI XORI ORI ANDI
      OP_STORE = 7'b0100011,                // SW
      OP_REG   = 7'b0110011,                // Register-register ALU
      OP_LUI   = 7'b0110111                 // Upper immediate
   } opcode_e;

   ////////////////////////////////////////////////////////////
   // ALU operations
   ////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,                    // Also address generation
      ALU_SUB    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_OR     = 4'd3,
      ALU_XOR    = 4'd4,
      ALU_SLT    = 4'd5,                    // Signed compare
      ALU_SLL    = 4'd6,
      ALU_SRL    = 4'd7,
      ALU_SRA    = 4'd8,
      ALU_PASS_B = 4'd9                     // LUI result
   } alu_op_e;

endpackage

/* hw/pipe_pkg.sv */
`include "core_defs.svh"

package pipe_pkg;

   // Fetch to decode, 65 bits
   typedef struct packed {
      logic                   valid;
      logic [`CORE_XLEN-1:0]  pc;
      logic [`CORE_XLEN-1:0]  instr;
   } fetch_t;

   // Decode to execute
   typedef struct packed {
      logic                       valid;
      logic [`CORE_XLEN-1:0]      pc;
      isa_pkg::alu_op_e           alu_op;
      logic [`CORE_XLEN-1:0]      operand_a;    // rs1 value
      logic [`CORE_XLEN-1:0]      operand_b;    // rs2 value or immediate
      logic [`CORE_XLEN-1:0]      store_data;   // rs2 value for SW
      logic [`CORE_REG_IDX_W-1:0] rd;
      logic                       wen;
      logic                       is_load;
      logic                       is_store;
   } issue_t;

   // Retire record and register write back, 71 bits
   typedef struct packed {
      logic                       valid;
      logic [`CORE_XLEN-1:0]      pc;
      logic [`CORE_REG_IDX_W-1:0] rd;
      logic                       wen;          // Never set for x0
      logic [`CORE_XLEN-1:0]      data;
   } retire_t;

endpackage

/* tests/core_tb.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;

   logic                  clk;
   logic                  reset;
   logic                  imem_en;
   logic [`CORE_XLEN-1:0] imem_data_in;
   pipe_pkg::retire_t     retire;

   logic [`CORE_XLEN-1:0] prog [$];                 // Program under test
   pipe_pkg::retire_t     exp_q [$];                // Expected retires in program order
   pipe_pkg::retire_t     exp_rec;
   logic [`CORE_XLEN-1:0] model_regs [`CORE_REG_COUNT];
   logic [`CORE_XLEN-1:0] model_mem [`CORE_DMEM_DEPTH];
   string                 test_name;
   integer                seed;
   int                    retire_errors = 0;        // Found by the compare process
   int                    flow_errors = 0;          // Missing retires
   int                    check_count = 0;
   int                    test_count = 0;
   int                    cycle_count = 0;
   int                    cycle_limit = 100;        // Startup margin that grows per test

   tb_clock_gen clock_gen (.clk(clk));

   core_top UUT (
      .clk          (clk),
      .reset        (reset),
      .imem_en      (imem_en),
      .imem_data_in (imem_data_in),
      .retire       (retire)
   );

   ////////////////////////////////////////////////////////////
   // Instruction encoders
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};                // OP-IMM and LOAD share the format
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};  // SW only
   endfunction

   ////////////////////////////////////////////////////////////
   // ISA reference model stepping one instruction per call
   ////////////////////////////////////////////////////////////

   function automatic pipe_pkg::retire_t model_step(input logic [31:0] pc,
                                                    input logic [31:0] ins);
      pipe_pkg::retire_t rec;
      logic [31:0]       a;
      logic [31:0]       b;
      logic [31:0]       imm_i;
      logic [31:0]       addr;
      logic [31:0]       res;
      logic              wr;
      a     = model_regs[ins[19:15]];
      b     = model_regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      res   = '0;
      wr    = 1'b1;                                 // Cleared for no-ops
      case (ins[6:0])
         7'h33: begin
            case (ins[14:12])
               3'd0: res = ins[30] ? a - b : a + b;
               3'd1: res = a << b[4:0];             // Low 5 bits of rs2
               3'd2: res = {31'b0, $signed(a) < $signed(b)};
               3'd4: res = a ^ b;
               3'd5: begin
                  if (ins[30])
                     res = $signed(a) >>> b[4:0];   // Sign fill
                  else
                     res = a >> b[4:0];
               end
               3'd6: res = a | b;
               3'd7: res = a & b;
               default: wr = 1'b0;                  // SLTU
            endcase
         end
         7'h13: begin
            case (ins[14:12])
               3'd0: res = a + imm_i;
               3'd2: res = {31'b0, $signed(a) < $signed(imm_i)};
               3'd4: res = a ^ imm_i;
               3'd6: res = a | imm_i;
               3'd7: res = a & imm_i;
               default: wr = 1'b0;                  // Immediate shifts and SLTIU
            endcase
         end
         7'h37: res = {ins[31:12], 12'b0};
         7'h03: begin
            addr = a + imm_i;
            wr   = (ins[14:12] == 3'd2);
            res  = model_mem[addr[9:2]];
         end
         7'h23: begin
            addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            wr   = 1'b0;
            if (ins[14:12] == 3'd2)
               model_mem[addr[9:2]] = b;
         end
         default: wr = 1'b0;
      endcase
      wr = wr && (ins[11:7] != 5'd0);               // x0 stays zero
      if (wr)
         model_regs[ins[11:7]] = res;
      rec       = '0;
      rec.valid = 1'b1;
      rec.pc    = pc;
      rec.rd    = ins[11:7];
      rec.wen   = wr;
      rec.data  = res;
      return rec;
   endfunction

   ////////////////////////////////////////////////////////////
   // Program builders
   ////////////////////////////////////////////////////////////

   task automatic put_const(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] upper;
      upper = value + 32'h800;                      // ADDI sign extends its low 12 bits
      prog.push_back({upper[31:12], rd, 7'h37});
      prog.push_back(enc_i(value[11:0], rd, 3'd0, rd, 7'h13));
   endtask

   task automatic push_alu_ops(input logic [4:0] rs1, input logic [4:0] rs2);
      prog.push_back(enc_r(7'h00, rs2, rs1, 3'd0, 5'd3));   // ADD
      prog.push_back(enc_r(7'h20, rs2, rs1, 3'd0, 5'd4));   // SUB
      prog.push_back(enc_r(7'h00, rs2, rs1, 3'd7, 5'd5));   // AND
      prog.push_back(enc_r(7'h00, rs2, rs1, 3'd6, 5'd6));   // OR
      prog.push_back(enc_r(7'h00, rs2, rs1, 3'd4, 5'd7));   // XOR
      prog.push_back(enc_r(7'h00, rs2, rs1, 3'd2, 5'd8));   // SLT
      prog.push_back(enc_r(7'h00, rs2, rs1, 3'd1, 5'd9));   // SLL
      prog.push_back(enc_r(7'h00, rs2, rs1, 3'd5, 5'd10));  // SRL
      prog.push_back(enc_r(7'h20, rs2, rs1, 3'd5, 5'd11));  // SRA
   endtask

   task automatic push_imm_ops(input logic [4:0] rs1);
      prog.push_back(enc_i(12'hffb, rs1, 3'd0, 5'd3, 7'h13));  // ADDI -5
      prog.push_back(enc_i(12'hf00, rs1, 3'd7, 5'd4, 7'h13));  // ANDI -256
      prog.push_back(enc_i(12'h800, rs1, 3'd6, 5'd5, 7'h13));  // ORI -2048
      prog.push_back(enc_i(12'hfff, rs1, 3'd4, 5'd6, 7'h13));  // XORI -1
      prog.push_back(enc_i(12'hfff, rs1, 3'd2, 5'd7, 7'h13));  // SLTI -1
      prog.push_back(enc_i(12'h7ff, rs1, 3'd2, 5'd8, 7'h13));  // SLTI 2047
      prog.push_back(enc_i(12'hff1, rs1, 3'd2, 5'd9, 7'h13));  // SLTI -15
   endtask

   task automatic alu_ops_program();
      prog.delete();
      repeat (3) begin
         put_const(5'd1, $random(seed));
         put_const(5'd2, $random(seed));
         push_alu_ops(5'd1, 5'd2);
      end
      put_const(5'd1, 32'h8000_0000);               // Most negative against positive
      put_const(5'd2, 32'h7fff_ffe3);               // Positive with shift amount 3 in the low bits
      push_alu_ops(5'd1, 5'd2);
      push_alu_ops(5'd2, 5'd1);
   endtask

   task automatic imm_ops_program();
      prog.delete();
      put_const(5'd1, $random(seed));
      push_imm_ops(5'd1);
      put_const(5'd1, 32'hffff_fff0);               // -16 for the SLTI edges
      push_imm_ops(5'd1);
      prog.push_back({20'h80001, 5'd10, 7'h37});    // LUI with the sign bit set
      prog.push_back({20'h00000, 5'd11, 7'h37});
   endtask

   task automatic chain_program();
      logic [4:0] rd;
      logic [4:0] prev;
      prog.delete();
      put_const(5'd1, $random(seed));
      put_const(5'd2, $random(seed));
      for (int i = 0; i < 12; i++) begin
         rd   = 5'(3 + i);
         prev = 5'(2 + i);
         case (i % 3)
            0: prog.push_back(enc_r(7'h00, prev, prev, 3'd0, rd));      // Both sources
            1: prog.push_back(enc_r(7'h00, prev, 5'd1, 3'd4, rd));      // On rs2
            default: prog.push_back(enc_r(7'h20, 5'd2, prev, 3'd5, rd)); // On rs1
         endcase
      end
      prog.push_back(enc_i(12'h7ff, 5'd14, 3'd0, 5'd15, 7'h13));
   endtask

   task automatic mem_program();
      prog.delete();
      put_const(5'd1, 32'h0000_0100);               // Base address
      put_const(5'd2, $random(seed));
      prog.push_back(enc_s(12'd0, 5'd2, 5'd1));
      prog.push_back(enc_i(12'd0, 5'd1, 3'd2, 5'd3, 7'h03));  // LW right after SW
      prog.push_back(enc_s(12'd8, 5'd3, 5'd1));
      put_const(5'd4, $random(seed));
      prog.push_back(enc_s(12'hffc, 5'd4, 5'd1));            // Negative offset
      prog.push_back(enc_i(12'd8, 5'd1, 3'd2, 5'd5, 7'h03));
      prog.push_back(enc_i(12'hffc, 5'd1, 3'd2, 5'd6, 7'h03));
      prog.push_back(enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd7));   // Load use
      prog.push_back(enc_i(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));  // Writes to x0
      prog.push_back(enc_r(7'h00, 5'd2, 5'd2, 3'd0, 5'd0));
      prog.push_back(enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd8));   // x0 reads as zero
      prog.push_back(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd9));
   endtask

   task automatic end_program();
      prog.delete();
      put_const(5'd1, $random(seed));
      prog.push_back({12'h000, 5'd1, 3'd0, 5'd5, 7'h0b});     // Custom-0 opcode
      prog.push_back(enc_i(12'd3, 5'd1, 3'd1, 5'd6, 7'h13));  // SLLI
      prog.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'd3, 5'd7));   // SLTU
      prog.push_back(enc_i(12'hfff, 5'd1, 3'd0, 5'd8, 7'h13));
   endtask

   task automatic reload_program();
      prog.delete();
      put_const(5'd3, $random(seed));
      prog.push_back(enc_i(12'd1, 5'd3, 3'd0, 5'd4, 7'h13));
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   task automatic run_test(input string name);
      int errors_before;
      int wait_cycles;
      int limit;
      errors_before = retire_errors + flow_errors;
      test_name     = name;
      test_count++;
      for (int r = 0; r < `CORE_REG_COUNT; r++)
         model_regs[r] = '0;
      exp_q.delete();
      foreach (prog[i])
         exp_q.push_back(model_step(32'(4 * i), prog[i]));
      limit       = 5 * prog.size() + 100;
      cycle_limit = cycle_limit + limit + prog.size();   // Load cycles on top
      @(negedge clk);
      reset   = 1'b1;
      imem_en = 1'b0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      foreach (prog[i]) begin
         imem_en      = 1'b1;                       // One word per cycle
         imem_data_in = prog[i];
         @(negedge clk);
      end
      imem_en      = 1'b0;
      imem_data_in = '0;
      wait_cycles  = 0;
      while (exp_q.size() != 0 && wait_cycles < limit) begin
         @(posedge clk);
         wait_cycles++;
      end
      assert (exp_q.size() == 0) else begin
         $display("%s: %0d instructions never retired", name, exp_q.size());
         flow_errors++;
      end
      repeat (20) @(negedge clk);                   // Extra retires get caught here
      $display("test %-8s %0d words: %s", name, prog.size(),
               (retire_errors + flow_errors == errors_before) ? "pass" : "fail");
   endtask

   task automatic compare_field(input string field, input logic [31:0] expv,
                                input logic [31:0] actv);
      check_count++;
      assert (actv === expv) else begin
         $display("error %s %s expected %h actual %h", test_name, field, expv, actv);
         retire_errors++;
      end
   endtask

   // Retire checker sampling mid-cycle
   always @(negedge clk) begin
      if (!reset && retire.valid) begin
         assert (exp_q.size() != 0) else begin
            $display("%s: extra retire at pc %h past the end of the program",
                     test_name, retire.pc);
            retire_errors++;
         end
         if (exp_q.size() != 0) begin
            exp_rec = exp_q.pop_front();
            compare_field("pc", exp_rec.pc, retire.pc);          // Also checks order
            compare_field("wen", 32'(exp_rec.wen), 32'(retire.wen));
            if (exp_rec.wen) begin
               compare_field("rd", 32'(exp_rec.rd), 32'(retire.rd));
               compare_field("data", exp_rec.data, retire.data);
            end
         end
      end
   end

   // Watchdog
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles in test %s", cycle_count, test_name);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      seed         = 27;
      reset        = 1'b1;
      imem_en      = 1'b0;
      imem_data_in = '0;
      test_name    = "startup";
      alu_ops_program();
      run_test("alu_ops");
      imm_ops_program();
      run_test("imm_ops");
      chain_program();
      run_test("chain");
      mem_program();
      run_test("mem_x0");
      end_program();
      run_test("end");
      reload_program();
      run_test("reload");
      $display("%0d tests, %0d checks, %0d errors", test_count, check_count,
               retire_errors + flow_errors);
      if (retire_errors + flow_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk
);

   localparam time HALF_PERIOD = 10ns;              // 20 ns clock

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

endmodule
